/* Makefile */
# Verilator build and run of the load unit testbench
TOP := tb_load_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+source
source/load_pkg.sv
source/dcache_pkg.sv
source/load_decode.sv
source/load_request_fsm.sv
source/load_result.sv
source/load_unit_top.sv
tb/tb_load_unit.sv

/* source/dcache_pkg.sv */
// Data cache port types
// request and response records of the load port of the data cache,
// which splits every access into an index phase and a tag phase
`include "load_unit_params.svh"

package dcache_pkg;

    // transfer size as the cache sees it
    typedef enum logic [1:0] {
        DC_BYTE, DC_HALF, DC_WORD, DC_DWORD
    } dc_size_e;

    // ------------------------------------------------------------
    // load unit to cache
    // ------------------------------------------------------------
    // data_req and index form the index phase and are held until gnt,
    // tag_valid and tag form the tag phase in the cycle after the grant
    typedef struct packed {
        logic                    data_req;
        logic [`DC_INDEX_W-1:0]  index;
        logic                    tag_valid;
        logic [`DC_TAG_W-1:0]    tag;
        logic [`LD_DATA_W/8-1:0] be;
        dc_size_e                size;
    } dc_req_t;

    // ------------------------------------------------------------
    // cache to load unit
    // ------------------------------------------------------------
    // rvalid can not be stalled, data comes back in request order
    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [`LD_DATA_W-1:0] rdata;
    } dc_rsp_t;

endpackage

/* source/load_decode.sv */
// Load operator decode
// turns a load request into the cache transfer size, the byte enables
// at the address offset, and the metadata that is queued until the
// data returns, including the precomputed sign byte index
`include "load_unit_params.svh"

module load_decode
    import load_pkg::*;
    import dcache_pkg::*;
(
    input  ld_req_t                 ld_req_i,
    output dc_size_e                size_o,
    output logic [`LD_DATA_W/8-1:0] be_o,
    output ld_meta_t                meta_o
);

    logic [1:0] width;
    ext_mode_e  ext;
    logic [2:0] offset;
    logic [3:0] nbytes;
    logic [7:0] base_be;

    // the byte offset inside the doubleword
    assign offset = ld_req_i.addr[2:0];

    // field width and fill mode per operator
    always_comb begin
        width = 2'd3;
        ext   = EXT_ZERO;
        unique case (ld_req_i.op)
            LW:  begin width = 2'd2; ext = EXT_SIGN; end
            LWU: begin width = 2'd2; ext = EXT_ZERO; end
            LH:  begin width = 2'd1; ext = EXT_SIGN; end
            LHU: begin width = 2'd1; ext = EXT_ZERO; end
            LB:  begin width = 2'd0; ext = EXT_SIGN; end
            LBU: begin width = 2'd0; ext = EXT_ZERO; end
            // narrow FP values are NaN boxed with ones
            FLW: begin width = 2'd2; ext = EXT_ONES; end
            FLH: begin width = 2'd1; ext = EXT_ONES; end
            FLB: begin width = 2'd0; ext = EXT_ONES; end
            default: ;
        endcase
    end

    assign nbytes = 4'd1 << width;

    // enables for a field at offset zero, moved up to the real offset below
    always_comb begin
        unique case (width)
            2'd0:    base_be = 8'h01;
            2'd1:    base_be = 8'h03;
            2'd2:    base_be = 8'h0f;
            default: base_be = 8'hff;
        endcase
    end

    assign size_o = dc_size_e'(width);
    assign be_o   = base_be << offset;

    // the sign byte is found here so the return path only has to pick a bit
    assign meta_o.trans_id = ld_req_i.trans_id;
    assign meta_o.offset   = offset;
    assign meta_o.width    = width;
    assign meta_o.ext      = ext;
    assign meta_o.sign_idx = offset + 3'(nbytes - 4'd1);

    // requests are naturally aligned upstream, so a field stays in one doubleword
    always_comb begin
        assert ({1'b0, offset} + nbytes <= 4'd8)
            else $error("load field crosses the doubleword boundary");
    end

endmodule

/* source/load_pkg.sv */
// Load unit types
// the load operator, the extension mode and the request, result and
// per-load metadata records that travel between the load unit blocks
`include "load_unit_params.svh"

package load_pkg;

    // ------------------------------------------------------------
    // operators and extension
    // ------------------------------------------------------------

    // integer loads plus the narrow floating point loads
    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU, FLW, FLH, FLB
    } ld_op_e;

    // how the bits above the loaded field are filled
    // a full doubleword has no bits above it and uses EXT_ZERO
    typedef enum logic [1:0] {
        EXT_ZERO, EXT_SIGN, EXT_ONES
    } ext_mode_e;

    // ------------------------------------------------------------
    // records
    // ------------------------------------------------------------

    // one load request, the address is already physical
    typedef struct packed {
        logic [`LD_TRANS_ID_W-1:0] trans_id;
        logic [`LD_ADDR_W-1:0]     addr;
        ld_op_e                    op;
    } ld_req_t;

    // kept per outstanding load until its data comes back
    // width is log2 of the field size in bytes, 0 byte up to 3 doubleword
    // sign_idx is the byte holding the top bit of the field
    typedef struct packed {
        logic [`LD_TRANS_ID_W-1:0] trans_id;
        logic [2:0]                offset;
        logic [1:0]                width;
        ext_mode_e                 ext;
        logic [2:0]                sign_idx;
    } ld_meta_t;

    // one load result
    typedef struct packed {
        logic [`LD_TRANS_ID_W-1:0] trans_id;
        logic [`LD_DATA_W-1:0]     result;
    } ld_rsp_t;

endpackage

/* source/load_request_fsm.sv */
// Load request FSM
// drives the index phase to the data cache, holds it until the grant,
// then presents the registered tag, byte enables and size one cycle later
// a new load may start in the tag cycle of the previous one
`include "load_unit_params.svh"

module load_request_fsm
    import load_pkg::*;
    import dcache_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    ld_valid_i,
    output logic                    ld_ready_o,
    input  ld_req_t                 ld_req_i,
    input  dc_size_e                size_i,
    input  logic [`LD_DATA_W/8-1:0] be_i,
    input  logic                    queue_full_i,
    output logic                    accept_o,
    output dc_req_t                 dc_req_o,
    input  logic                    dc_gnt_i
);

    typedef enum logic [1:0] {
        IDLE, WAIT_GNT, SEND_TAG
    } state_e;

    state_e                  state_d, state_q;
    logic                    start;
    logic                    data_req;
    logic                    accept;
    logic [`DC_TAG_W-1:0]    tag_q;
    logic [`LD_DATA_W/8-1:0] be_q;
    dc_size_e                size_q;

    // a request only goes out when its metadata has a queue slot
    assign start = ld_valid_i && !queue_full_i;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        state_d  = state_q;
        data_req = 1'b0;
        accept   = 1'b0;
        unique case (state_q)
            // the tag cycle is free for the index phase of the next load
            IDLE, SEND_TAG: begin
                state_d = IDLE;
                if (start) begin
                    data_req = 1'b1;
                    if (dc_gnt_i) begin
                        accept  = 1'b1;
                        state_d = SEND_TAG;
                    end else begin
                        state_d = WAIT_GNT;
                    end
                end
            end
            // index phase stays up until the cache takes it
            WAIT_GNT: begin
                data_req = 1'b1;
                if (dc_gnt_i) begin
                    accept  = 1'b1;
                    state_d = SEND_TAG;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // the handshake completes in the grant cycle
    assign ld_ready_o = accept;
    assign accept_o   = accept;

    // ------------------------------------------------------------
    // cache request
    // ------------------------------------------------------------
    always_comb begin
        dc_req_o.data_req  = data_req;
        dc_req_o.index     = ld_req_i.addr[`DC_INDEX_W-1:0];
        dc_req_o.tag_valid = (state_q == SEND_TAG);
        dc_req_o.tag       = tag_q;
        dc_req_o.be        = be_q;
        dc_req_o.size      = size_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // tag phase fields of the accepted load, the requester moves on after ready
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_q  <= ld_req_i.addr[`LD_ADDR_W-1:`DC_INDEX_W];
            be_q   <= be_i;
            size_q <= size_i;
        end
    end

    // ------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------
    // the tag phase belongs to the grant of the cycle before
    tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dc_req_o.tag_valid |-> $past(dc_req_o.data_req && dc_gnt_i));

    // ready needs a granted index phase and a free queue slot
    ready_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_ready_o |-> (dc_gnt_i && dc_req_o.data_req && !queue_full_i));

endmodule

/* source/load_result.sv */
// Load result path
// keeps the metadata of every load in flight in a small FIFO and,
// when the cache returns data, realigns it and fills the upper bits
// with zeros, the sign or ones, all in the cycle of rvalid
`include "load_unit_params.svh"

module load_result
    import load_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  push_i,
    input  ld_meta_t              meta_i,
    output logic                  queue_full_o,
    input  logic                  dc_rvalid_i,
    input  logic [`LD_DATA_W-1:0] dc_rdata_i,
    output logic                  ld_valid_o,
    output ld_rsp_t               ld_rsp_o
);

    localparam int unsigned PTR_W = $clog2(`LD_QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `LD_QUEUE_DEPTH;

    ld_meta_t              queue_q [`LD_QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]        count_q;
    logic                  empty;
    ld_meta_t              head;
    logic [`LD_DATA_W-1:0] shifted;
    logic [7:0]            sign_bits;
    logic                  fill;

    // ------------------------------------------------------------
    // metadata FIFO
    // ------------------------------------------------------------
    assign queue_full_o = (count_q == DEPTH);
    assign empty        = (count_q == '0);
    assign head         = queue_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            // data returns in order so the head is always the answered load
            if (dc_rvalid_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i && !dc_rvalid_i) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && dc_rvalid_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            queue_q[wr_ptr_q] <= meta_i;
        end
    end

    // ------------------------------------------------------------
    // realign and extend
    // ------------------------------------------------------------
    assign shifted = dc_rdata_i >> {head.offset, 3'b000};

    // top bit of each byte, picked in parallel with the shifter
    assign sign_bits = {dc_rdata_i[63], dc_rdata_i[55], dc_rdata_i[47], dc_rdata_i[39],
                        dc_rdata_i[31], dc_rdata_i[23], dc_rdata_i[15], dc_rdata_i[7]};

    always_comb begin
        unique case (head.ext)
            EXT_SIGN: fill = sign_bits[head.sign_idx];
            EXT_ONES: fill = 1'b1;
            default:  fill = 1'b0;
        endcase
    end

    always_comb begin
        ld_rsp_o.trans_id = head.trans_id;
        unique case (head.width)
            2'd0:    ld_rsp_o.result = {{56{fill}}, shifted[7:0]};
            2'd1:    ld_rsp_o.result = {{48{fill}}, shifted[15:0]};
            2'd2:    ld_rsp_o.result = {{32{fill}}, shifted[31:0]};
            default: ld_rsp_o.result = shifted;
        endcase
    end

    // the cache return can not be stalled, so the result is valid with it
    assign ld_valid_o = dc_rvalid_i;

    // ------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------
    // the request side must hold back while every slot is taken
    no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !queue_full_o);

    // the cache only answers loads it has granted
    no_rvalid_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dc_rvalid_i |-> !empty);

endmodule

/* source/load_unit_params.svh */
// Load unit constants
// widths of the data path, the address and the cache address split,
// and the number of loads that may be outstanding at the cache
`ifndef LOAD_UNIT_PARAMS_SVH
`define LOAD_UNIT_PARAMS_SVH

// ------------------------------------------------------------
// data path and request fields
// ------------------------------------------------------------
`define LD_DATA_W      64
`define LD_TRANS_ID_W  3
`define LD_ADDR_W      32

// ------------------------------------------------------------
// cache address split, index is the low part of the address
// ------------------------------------------------------------
`define DC_INDEX_W     12
`define DC_TAG_W       20

// loads accepted by the cache but not yet returned
`define LD_QUEUE_DEPTH 4

`endif

/* source/load_unit_top.sv */
// Load unit
// accepts physical load requests, issues them to the data cache port
// and returns the realigned and extended doubleword with its id
`include "load_unit_params.svh"

module load_unit_top
    import load_pkg::*;
    import dcache_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    // load requests
    input  logic    ld_valid_i,
    output logic    ld_ready_o,
    input  ld_req_t ld_req_i,
    // load results
    output logic    ld_valid_o,
    output ld_rsp_t ld_rsp_o,
    // data cache port
    output dc_req_t dc_req_o,
    input  dc_rsp_t dc_rsp_i
);

    dc_size_e                dec_size;
    logic [`LD_DATA_W/8-1:0] dec_be;
    ld_meta_t                dec_meta;
    logic                    accept;
    logic                    queue_full;

    // ------------------------------------------------------------
    // operator decode
    // ------------------------------------------------------------
    load_decode u_decode (
        .ld_req_i (ld_req_i),
        .size_o   (dec_size),
        .be_o     (dec_be),
        .meta_o   (dec_meta)
    );

    // ------------------------------------------------------------
    // cache request side
    // ------------------------------------------------------------
    load_request_fsm u_request (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ld_valid_i   (ld_valid_i),
        .ld_ready_o   (ld_ready_o),
        .ld_req_i     (ld_req_i),
        .size_i       (dec_size),
        .be_i         (dec_be),
        .queue_full_i (queue_full),
        .accept_o     (accept),
        .dc_req_o     (dc_req_o),
        .dc_gnt_i     (dc_rsp_i.gnt)
    );

    // ------------------------------------------------------------
    // pending loads and data return
    // ------------------------------------------------------------
    load_result u_result (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (accept),
        .meta_i       (dec_meta),
        .queue_full_o (queue_full),
        .dc_rvalid_i  (dc_rsp_i.rvalid),
        .dc_rdata_i   (dc_rsp_i.rdata),
        .ld_valid_o   (ld_valid_o),
        .ld_rsp_o     (ld_rsp_o)
    );

endmodule

/* tb/tb_load_unit.sv */
// Load unit testbench
// applies a table of loads through a behavioral data cache model with
// random grant and return delays, and checks every tag phase and result
`include "load_unit_params.svh"

module tb_load_unit
    import load_pkg::*;
    import dcache_pkg::*;
;

    localparam int WAIT_LIMIT = 60;

    // one table row, the stimulus followed by what the DUT must produce
    typedef struct packed {
        ld_op_e      op;
        logic [31:0] addr;
        logic [2:0]  id;
        logic [7:0]  be;
        dc_size_e    size;
        logic [63:0] result;
    } row_t;

    // a granted load waiting in the cache model for its data return
    typedef struct packed {
        logic [63:0] data;
        logic [1:0]  wait_cnt;
    } ret_t;

    logic    clk;
    logic    rst_n;
    logic    ld_valid;
    logic    ld_ready;
    ld_req_t ld_req;
    logic    rsp_valid;
    ld_rsp_t rsp;
    dc_req_t dc_req;
    dc_rsp_t dc_rsp;

    row_t        rows[$];
    int          tag_rows[$];
    int          rsp_rows[$];
    ret_t        ret_q[$];
    int unsigned gnt_wait = 0;
    logic        granted_q = 1'b0;
    logic [11:0] gnt_index = '0;
    logic        hold_rvalid = 1'b0;

    load_unit_top UUT (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .ld_valid_i (ld_valid),
        .ld_ready_o (ld_ready),
        .ld_req_i   (ld_req),
        .ld_valid_o (rsp_valid),
        .ld_rsp_o   (rsp),
        .dc_req_o   (dc_req),
        .dc_rsp_i   (dc_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model of memory and load rules
    // ------------------------------------------------------------
    // every byte of the 64 byte window gets its own value, top bits mixed
    function automatic logic [7:0] mem_byte(input logic [5:0] a);
        return 8'({2'b00, a} * 8'd53) ^ 8'hc6;
    endfunction

    function automatic logic [63:0] dword(input logic [2:0] idx);
        logic [63:0] d;
        for (int k = 0; k < 8; k++) begin
            d[8*k +: 8] = mem_byte({idx, 3'(k)});
        end
        return d;
    endfunction

    function automatic int op_bytes(input ld_op_e op);
        case (op)
            LD:            return 8;
            LW, LWU, FLW:  return 4;
            LH, LHU, FLH:  return 2;
            default:       return 1;
        endcase
    endfunction

    function automatic ext_mode_e op_mode(input ld_op_e op);
        case (op)
            LW, LH, LB:    return EXT_SIGN;
            FLW, FLH, FLB: return EXT_ONES;
            default:       return EXT_ZERO;
        endcase
    endfunction

    function automatic logic [7:0] expected_be(input int nb, input int off);
        logic [7:0] be;
        for (int k = 0; k < 8; k++) begin
            be[k] = (k >= off) && (k < off + nb);
        end
        return be;
    endfunction

    function automatic dc_size_e expected_size(input int nb);
        case (nb)
            1:       return DC_BYTE;
            2:       return DC_HALF;
            4:       return DC_WORD;
            default: return DC_DWORD;
        endcase
    endfunction

    // gather the field byte by byte, then fill everything above it
    function automatic logic [63:0] expected_result(input ld_op_e op, input logic [31:0] addr);
        logic [63:0] val;
        logic        fill;
        int          nb;
        nb  = op_bytes(op);
        val = '0;
        for (int k = 0; k < nb; k++) begin
            val[8*k +: 8] = mem_byte(addr[5:0] + 6'(k));
        end
        case (op_mode(op))
            EXT_SIGN: fill = val[8*nb-1];
            EXT_ONES: fill = 1'b1;
            default:  fill = 1'b0;
        endcase
        for (int k = 8 * nb; k < 64; k++) begin
            val[k] = fill;
        end
        return val;
    endfunction

    // each operator at every aligned offset, spread over all eight doublewords
    task automatic build_table();
        row_t row;
        int   nb;
        int   n;
        n = 0;
        for (int o = 0; o < 10; o++) begin
            nb = op_bytes(ld_op_e'(o));
            for (int off = 0; off + nb <= 8; off += nb) begin
                row.op     = ld_op_e'(o);
                row.addr   = 32'h4000_0000 | (32'(n) << 12) | (32'(n % 8) << 3) | 32'(off);
                row.id     = 3'(n);
                row.be     = expected_be(nb, off);
                row.size   = expected_size(nb);
                row.result = expected_result(row.op, row.addr);
                rows.push_back(row);
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_rsp(input ld_rsp_t got, input ld_rsp_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: ld_rsp_o got id %0d data %h expected id %0d data %h",
                     $time, got.trans_id, got.result, want.trans_id, want.result);
            abort_run();
        end
    endtask

    task automatic check_index(input logic [`DC_INDEX_W-1:0] got,
                               input logic [`DC_INDEX_W-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: dc_req_o.index got %h expected %h",
                     $time, got, want);
            abort_run();
        end
    endtask

    task automatic check_dc_req(input logic [7:0] be, input dc_size_e size,
                                input logic [`DC_TAG_W-1:0] tag,
                                input logic [7:0] be_want, input dc_size_e size_want,
                                input logic [`DC_TAG_W-1:0] tag_want);
        if (be !== be_want) begin
            $display("CHECK FAILED at %0t: dc_req_o.be got %h expected %h", $time, be, be_want);
            abort_run();
        end
        if (size !== size_want) begin
            $display("CHECK FAILED at %0t: dc_req_o.size got %s expected %s",
                     $time, size.name(), size_want.name());
            abort_run();
        end
        if (tag !== tag_want) begin
            $display("CHECK FAILED at %0t: dc_req_o.tag got %h expected %h",
                     $time, tag, tag_want);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // cache model and result receiver
    // ------------------------------------------------------------
    // sampled on the rising edge, so all values are the settled ones
    always @(posedge clk) begin
        ld_rsp_t want;
        ret_t    ent;
        int      r;
        if (rst_n) begin
            // ready is exactly the grant of a requested index phase
            check_bit("ld_ready_o", ld_ready, dc_req.data_req && dc_rsp.gnt);
            check_bit("dc_req_o.tag_valid", dc_req.tag_valid, granted_q);
            // the index phase carries the low address bits of the load being driven
            if (dc_req.data_req) begin
                check_index(dc_req.index, ld_req.addr[`DC_INDEX_W-1:0]);
            end
            if (dc_req.tag_valid) begin
                if (tag_rows.size() == 0) begin
                    $display("a tag phase came at %0t with no granted load", $time);
                    abort_run();
                end else begin
                    r = tag_rows.pop_front();
                    check_dc_req(dc_req.be, dc_req.size, dc_req.tag,
                                 rows[r].be, rows[r].size,
                                 rows[r].addr[`LD_ADDR_W-1:`DC_INDEX_W]);
                end
            end
            if (rsp_valid) begin
                if (rsp_rows.size() == 0) begin
                    $display("a result came out at %0t with no load pending", $time);
                    abort_run();
                end else begin
                    r = rsp_rows.pop_front();
                    want.trans_id = rows[r].id;
                    want.result   = rows[r].result;
                    check_rsp(rsp, want);
                end
            end
            // data returns in order, only the head counts down
            if (dc_rsp.rvalid) begin
                void'(ret_q.pop_front());
            end
            if (ret_q.size() != 0 && ret_q[0].wait_cnt != 0) begin
                ent = ret_q[0];
                ent.wait_cnt = ent.wait_cnt - 2'd1;
                ret_q[0] = ent;
            end
            if (dc_req.tag_valid) begin
                ent.data     = dword(gnt_index[5:3]);
                ent.wait_cnt = 2'($urandom % 3);
                ret_q.push_back(ent);
            end
            granted_q = dc_req.data_req && dc_rsp.gnt;
            if (granted_q) begin
                gnt_index = dc_req.index;
                gnt_wait  = $urandom % 3;
            end else if (dc_req.data_req && gnt_wait != 0) begin
                gnt_wait--;
            end
        end
    end

    initial begin
        dc_rsp = '0;
        forever begin
            @(negedge clk);
            dc_rsp.gnt = (gnt_wait == 0);
            if (!hold_rvalid && ret_q.size() != 0 && ret_q[0].wait_cnt == 0) begin
                dc_rsp.rvalid = 1'b1;
                dc_rsp.rdata  = ret_q[0].data;
            end else begin
                dc_rsp.rvalid = 1'b0;
                dc_rsp.rdata  = '0;
            end
        end
    end

    // ------------------------------------------------------------
    // request driver
    // ------------------------------------------------------------
    task automatic drive_row(input int r);
        @(negedge clk);
        ld_valid        = 1'b1;
        ld_req.trans_id = rows[r].id;
        ld_req.addr     = rows[r].addr;
        ld_req.op       = rows[r].op;
    endtask

    task automatic wait_accept(input int r);
        int waited;
        bit done;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (ld_ready) begin
                done = 1'b1;
            end else if (waited == WAIT_LIMIT) begin
                $display("timeout: load of row %0d was never accepted", r);
                abort_run();
            end else begin
                waited++;
            end
        end
        tag_rows.push_back(r);
        rsp_rows.push_back(r);
    endtask

    task automatic end_request();
        @(negedge clk);
        ld_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (rsp_rows.size() != 0) begin
            @(negedge clk);
            if (waited == WAIT_LIMIT) begin
                $display("timeout: %0d loads never returned a result", rsp_rows.size());
                abort_run();
            end else begin
                waited++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'he62a));
        rst_n    = 1'b0;
        ld_valid = 1'b0;
        ld_req   = '0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_bit("ld_ready_o", ld_ready, 1'b0);
        check_bit("dc_req_o.data_req", dc_req.data_req, 1'b0);
        check_bit("dc_req_o.tag_valid", dc_req.tag_valid, 1'b0);
        check_bit("ld_valid_o", rsp_valid, 1'b0);

        // every row back to back with random grant and return delays
        foreach (rows[r]) begin
            drive_row(r);
            wait_accept(r);
        end
        end_request();
        wait_drained();

        // fill the queue with rvalid withheld, the next load must wait
        @(posedge clk);
        hold_rvalid = 1'b1;
        for (int r = 0; r < `LD_QUEUE_DEPTH; r++) begin
            drive_row(r);
            wait_accept(r);
        end
        drive_row(`LD_QUEUE_DEPTH);
        repeat (6) begin
            @(posedge clk);
            check_bit("ld_ready_o", ld_ready, 1'b0);
            check_bit("dc_req_o.data_req", dc_req.data_req, 1'b0);
        end
        hold_rvalid = 1'b0;
        wait_accept(`LD_QUEUE_DEPTH);
        end_request();
        wait_drained();

        $display("Everything OK");
        $finish;
    end

endmodule
